//--- tetris_pkg.sv
package tetris_pkg;

    localparam int COLS = 10;
    localparam int ROWS = 20;

    typedef logic [3:0] col_t;
    typedef logic [4:0] row_t;
    typedef logic [2:0] cell_t;
    typedef logic [2:0] shape_t;
    typedef logic [1:0] rot_t;
    typedef logic [9:0] coord_t;

    // Indexed as [col][row], row 0 at the top
    typedef cell_t [COLS-1:0][ROWS-1:0] board_t;

    typedef struct packed {
        col_t col;
        row_t row;
    } pos_t;

    typedef pos_t [3:0] cells_t;

    typedef struct packed {
        logic signed [2:0] dc;
        logic signed [2:0] dr;
    } offset_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    localparam col_t SPAWN_COL = 4'd4;
    localparam row_t SPAWN_ROW = 5'd0;

    // Three cells around the anchor, per shape and rotation
    localparam offset_t SHAPE_OFFSETS [7][4][3] = '{
        // Z
        '{'{'{-3'sd1, 3'sd0}, '{3'sd0, 3'sd1}, '{3'sd1, 3'sd1}},
          '{'{3'sd0, -3'sd1}, '{-3'sd1, 3'sd0}, '{-3'sd1, 3'sd1}},
          '{'{-3'sd1, 3'sd0}, '{3'sd0, 3'sd1}, '{3'sd1, 3'sd1}},
          '{'{3'sd0, -3'sd1}, '{-3'sd1, 3'sd0}, '{-3'sd1, 3'sd1}}},
        // S
        '{'{'{-3'sd1, 3'sd1}, '{3'sd0, 3'sd1}, '{3'sd1, 3'sd0}},
          '{'{-3'sd1, -3'sd1}, '{-3'sd1, 3'sd0}, '{3'sd0, 3'sd1}},
          '{'{-3'sd1, 3'sd1}, '{3'sd0, 3'sd1}, '{3'sd1, 3'sd0}},
          '{'{-3'sd1, -3'sd1}, '{-3'sd1, 3'sd0}, '{3'sd0, 3'sd1}}},
        // T
        '{'{'{-3'sd1, 3'sd0}, '{3'sd0, 3'sd1}, '{3'sd1, 3'sd0}},
          '{'{-3'sd1, 3'sd0}, '{3'sd0, -3'sd1}, '{3'sd0, 3'sd1}},
          '{'{-3'sd1, 3'sd0}, '{3'sd0, -3'sd1}, '{3'sd1, 3'sd0}},
          '{'{3'sd0, -3'sd1}, '{3'sd1, 3'sd0}, '{3'sd0, 3'sd1}}},
        // I
        '{'{'{-3'sd1, 3'sd0}, '{3'sd1, 3'sd0}, '{3'sd2, 3'sd0}},
          '{'{3'sd0, -3'sd1}, '{3'sd0, 3'sd1}, '{3'sd0, 3'sd2}},
          '{'{-3'sd1, 3'sd0}, '{3'sd1, 3'sd0}, '{3'sd2, 3'sd0}},
          '{'{3'sd0, -3'sd1}, '{3'sd0, 3'sd1}, '{3'sd0, 3'sd2}}},
        // J
        '{'{'{-3'sd1, 3'sd0}, '{3'sd1, 3'sd0}, '{3'sd1, 3'sd1}},
          '{'{-3'sd1, 3'sd1}, '{3'sd0, -3'sd1}, '{3'sd0, 3'sd1}},
          '{'{-3'sd1, -3'sd1}, '{-3'sd1, 3'sd0}, '{3'sd1, 3'sd0}},
          '{'{3'sd0, -3'sd1}, '{3'sd0, 3'sd1}, '{3'sd1, -3'sd1}}},
        // L
        '{'{'{-3'sd1, 3'sd0}, '{-3'sd1, 3'sd1}, '{3'sd1, 3'sd0}},
          '{'{-3'sd1, -3'sd1}, '{3'sd0, -3'sd1}, '{3'sd0, 3'sd1}},
          '{'{-3'sd1, 3'sd0}, '{3'sd1, 3'sd0}, '{3'sd1, -3'sd1}},
          '{'{3'sd0, -3'sd1}, '{3'sd0, 3'sd1}, '{3'sd1, 3'sd1}}},
        // O, same for every rotation
        '{'{'{3'sd0, 3'sd1}, '{3'sd1, 3'sd0}, '{3'sd1, 3'sd1}},
          '{'{3'sd0, 3'sd1}, '{3'sd1, 3'sd0}, '{3'sd1, 3'sd1}},
          '{'{3'sd0, 3'sd1}, '{3'sd1, 3'sd0}, '{3'sd1, 3'sd1}},
          '{'{3'sd0, 3'sd1}, '{3'sd1, 3'sd0}, '{3'sd1, 3'sd1}}}
    };

    localparam rgb_t CELL_COLORS [8] = '{
        '{8'd20, 8'd20, 8'd20},
        '{8'd255, 8'd20, 8'd20},
        '{8'd20, 8'd255, 8'd20},
        '{8'd20, 8'd20, 8'd255},
        '{8'd20, 8'd255, 8'd255},
        '{8'd255, 8'd20, 8'd255},
        '{8'd255, 8'd255, 8'd20},
        '{8'd255, 8'd100, 8'd0}
    };
    localparam rgb_t GRID_COLOR = '{8'd255, 8'd255, 8'd255};
    localparam rgb_t GHOST_COLOR = '{8'd180, 8'd180, 8'd180};
    localparam rgb_t BACK_COLOR = '{8'd20, 8'd20, 8'd20};

    localparam int FIELD_X0 = 220;
    localparam int FIELD_Y0 = 40;
    localparam int CELL_PIX = 20;

    // PS/2 scan codes of the arrow keys
    localparam logic [7:0] KEY_UP = 8'h75;
    localparam logic [7:0] KEY_DOWN = 8'h72;
    localparam logic [7:0] KEY_RIGHT = 8'h74;
    localparam logic [7:0] KEY_LEFT = 8'h6B;

    localparam int GRAVITY_CYCLES = 2048;
    localparam int SETTLE_CYCLES = 32;

endpackage

//--- piece_cells.sv
module piece_cells (
    input  tetris_pkg::col_t   i_col,
    input  tetris_pkg::row_t   i_row,
    input  tetris_pkg::shape_t i_shape,
    input  tetris_pkg::rot_t   i_rot,
    output tetris_pkg::cells_t o_cells,
    output logic [3:0]         o_inside
);

    tetris_pkg::offset_t offs [4];
    // One spare bit, so a step below zero wraps far out of range
    logic [4:0] col_ext [4];
    logic [5:0] row_ext [4];

    always_comb begin
        offs[0] = '{dc: 3'sd0, dr: 3'sd0};
        for (int k = 0; k < 3; k++) begin
            offs[k+1] = tetris_pkg::SHAPE_OFFSETS[i_shape][i_rot][k];
        end
        for (int k = 0; k < 4; k++) begin
            col_ext[k] = {1'b0, i_col} + {{2{offs[k].dc[2]}}, offs[k].dc};
            row_ext[k] = {1'b0, i_row} + {{3{offs[k].dr[2]}}, offs[k].dr};
            o_cells[k].col = col_ext[k][3:0];
            o_cells[k].row = row_ext[k][4:0];
            o_inside[k] = (col_ext[k] < 5'(tetris_pkg::COLS))
                       && (row_ext[k] < 6'(tetris_pkg::ROWS));
        end
    end

endmodule

//--- piece_fit.sv
module piece_fit (
    input  tetris_pkg::cells_t i_cells,
    input  logic [3:0]         i_inside,
    input  tetris_pkg::board_t i_board,
    output logic               o_fits
);

    logic [3:0] cell_free;

    always_comb begin
        for (int k = 0; k < 4; k++) begin
            // Board only looked up for cells on the field
            cell_free[k] = i_inside[k]
                ? (i_board[i_cells[k].col][i_cells[k].row] == '0)
                : 1'b0;
        end
    end

    assign o_fits = &cell_free;

endmodule

//--- board_store.sv
module board_store (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_clear,
    input  logic               i_lock_we,
    input  tetris_pkg::cells_t i_lock_cells,
    input  tetris_pkg::cell_t  i_lock_code,
    input  logic               i_row_check,
    input  tetris_pkg::row_t   i_row_idx,
    output tetris_pkg::board_t o_board
);

    logic               row_full;
    tetris_pkg::board_t shifted;

    // Rows above the checked one drop by one, top row empties
    always_comb begin
        row_full = 1'b1;
        for (int c = 0; c < tetris_pkg::COLS; c++) begin
            if (o_board[c][i_row_idx] == '0) begin
                row_full = 1'b0;
            end
            for (int r = 0; r < tetris_pkg::ROWS; r++) begin
                if (r == 0) begin
                    shifted[c][r] = '0;
                end else if (r <= i_row_idx) begin
                    shifted[c][r] = o_board[c][r-1];
                end else begin
                    shifted[c][r] = o_board[c][r];
                end
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_board <= '0;
        end else if (i_clear) begin
            o_board <= '0;
        end else if (i_lock_we) begin
            for (int k = 0; k < 4; k++) begin
                o_board[i_lock_cells[k].col][i_lock_cells[k].row] <= i_lock_code;
            end
        end else if (i_row_check && row_full) begin
            o_board <= shifted;
        end
    end

endmodule

//--- game_fsm.sv
module game_fsm (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_start,
    input  logic [7:0]         i_key,
    input  tetris_pkg::board_t i_board,
    output logic               o_board_clear,
    output logic               o_lock_we,
    output tetris_pkg::cells_t o_lock_cells,
    output tetris_pkg::cell_t  o_lock_code,
    output logic               o_row_check,
    output tetris_pkg::row_t   o_row_idx,
    output tetris_pkg::cells_t o_active_cells,
    output tetris_pkg::cells_t o_ghost_cells,
    output tetris_pkg::cell_t  o_active_code
);

    localparam int GRAV_W = $clog2(tetris_pkg::GRAVITY_CYCLES);
    localparam int SETTLE_W = $clog2(tetris_pkg::SETTLE_CYCLES);

    typedef enum logic [2:0] {S_IDLE, S_SETTLE, S_WAIT, S_LOCK, S_CLEAR} state_t;

    state_t              state;
    tetris_pkg::col_t    anchor_col;
    tetris_pkg::row_t    anchor_row;
    tetris_pkg::row_t    ghost_row;
    tetris_pkg::shape_t  shape;
    tetris_pkg::rot_t    rot;
    tetris_pkg::row_t    scan_row;
    logic [GRAV_W-1:0]   grav_cnt;
    logic [SETTLE_W-1:0] settle_cnt;
    logic [7:0]          key_prev;
    logic [7:0]          key_code;
    logic                key_pend;
    logic                key_event;
    tetris_pkg::cell_t   piece_code;
    tetris_pkg::col_t    cand_col;
    tetris_pkg::rot_t    cand_rot;
    tetris_pkg::cells_t  active_cells;
    tetris_pkg::cells_t  cand_cells;
    tetris_pkg::cells_t  ghost_cells;
    tetris_pkg::cells_t  below_cells;
    logic [3:0]          cand_inside;
    logic [3:0]          below_inside;
    logic                cand_fits;
    logic                below_fits;

    // New arrow code on the key bus
    assign key_event = (i_key != key_prev)
                    && (i_key == tetris_pkg::KEY_UP || i_key == tetris_pkg::KEY_DOWN
                     || i_key == tetris_pkg::KEY_LEFT || i_key == tetris_pkg::KEY_RIGHT);

    assign piece_code = shape + 3'd1;

    always_comb begin
        cand_col = anchor_col;
        cand_rot = rot;
        case (key_code)
            tetris_pkg::KEY_LEFT:  cand_col = anchor_col - 4'd1;
            tetris_pkg::KEY_RIGHT: cand_col = anchor_col + 4'd1;
            tetris_pkg::KEY_UP:    cand_rot = rot + 2'd1;
            default: ;
        endcase
    end

    piece_cells u_active (
        .i_col    (anchor_col),
        .i_row    (anchor_row),
        .i_shape  (shape),
        .i_rot    (rot),
        .o_cells  (active_cells),
        .o_inside ()
    );

    piece_cells u_cand (
        .i_col    (cand_col),
        .i_row    (anchor_row),
        .i_shape  (shape),
        .i_rot    (cand_rot),
        .o_cells  (cand_cells),
        .o_inside (cand_inside)
    );

    piece_cells u_ghost (
        .i_col    (anchor_col),
        .i_row    (ghost_row),
        .i_shape  (shape),
        .i_rot    (rot),
        .o_cells  (ghost_cells),
        .o_inside ()
    );

    piece_cells u_below (
        .i_col    (anchor_col),
        .i_row    (ghost_row + 5'd1),
        .i_shape  (shape),
        .i_rot    (rot),
        .o_cells  (below_cells),
        .o_inside (below_inside)
    );

    piece_fit u_cand_fit (
        .i_cells  (cand_cells),
        .i_inside (cand_inside),
        .i_board  (i_board),
        .o_fits   (cand_fits)
    );

    piece_fit u_below_fit (
        .i_cells  (below_cells),
        .i_inside (below_inside),
        .i_board  (i_board),
        .o_fits   (below_fits)
    );

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state      <= S_IDLE;
            anchor_col <= tetris_pkg::SPAWN_COL;
            anchor_row <= tetris_pkg::SPAWN_ROW;
            ghost_row  <= tetris_pkg::SPAWN_ROW;
            shape      <= '0;
            rot        <= '0;
            scan_row   <= '0;
            grav_cnt   <= '0;
            settle_cnt <= '0;
            key_prev   <= '0;
            key_code   <= '0;
            key_pend   <= 1'b0;
        end else begin
            key_prev <= i_key;
            // A fresh event overrides both an older one and consumption
            if (key_event) begin
                key_code <= i_key;
                key_pend <= 1'b1;
            end else if (state == S_WAIT) begin
                key_pend <= 1'b0;
            end

            case (state)
                S_IDLE: begin
                    if (i_start) begin
                        shape      <= '0;
                        rot        <= '0;
                        anchor_col <= tetris_pkg::SPAWN_COL;
                        anchor_row <= tetris_pkg::SPAWN_ROW;
                        ghost_row  <= tetris_pkg::SPAWN_ROW;
                        settle_cnt <= '0;
                        state      <= S_SETTLE;
                    end
                end
                S_SETTLE: begin
                    settle_cnt <= settle_cnt + 1'b1;
                    if (below_fits) begin
                        ghost_row <= ghost_row + 5'd1;
                    end
                    if (settle_cnt == SETTLE_W'(tetris_pkg::SETTLE_CYCLES - 1)) begin
                        grav_cnt <= '0;
                        // Stuck on the top row means game over
                        state    <= (ghost_row == '0) ? S_IDLE : S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (key_pend) begin
                        if (key_code == tetris_pkg::KEY_DOWN) begin
                            anchor_row <= ghost_row;
                            state      <= S_LOCK;
                        end else if (cand_fits) begin
                            anchor_col <= cand_col;
                            rot        <= cand_rot;
                            ghost_row  <= anchor_row;
                            settle_cnt <= '0;
                            state      <= S_SETTLE;
                        end
                    end else if (grav_cnt == GRAV_W'(tetris_pkg::GRAVITY_CYCLES - 1)) begin
                        grav_cnt <= '0;
                        if (anchor_row == ghost_row) begin
                            state <= S_LOCK;
                        end else begin
                            anchor_row <= anchor_row + 5'd1;
                        end
                    end else begin
                        grav_cnt <= grav_cnt + 1'b1;
                    end
                end
                S_LOCK: begin
                    scan_row <= '0;
                    state    <= S_CLEAR;
                end
                S_CLEAR: begin
                    scan_row <= scan_row + 5'd1;
                    if (scan_row == tetris_pkg::row_t'(tetris_pkg::ROWS - 1)) begin
                        shape      <= (shape == 3'd6) ? 3'd0 : shape + 3'd1;
                        rot        <= '0;
                        anchor_col <= tetris_pkg::SPAWN_COL;
                        anchor_row <= tetris_pkg::SPAWN_ROW;
                        ghost_row  <= tetris_pkg::SPAWN_ROW;
                        settle_cnt <= '0;
                        state      <= S_SETTLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    assign o_board_clear = (state == S_IDLE) && i_start;
    assign o_lock_we     = (state == S_LOCK);
    assign o_lock_cells  = ghost_cells;
    assign o_lock_code   = piece_code;
    assign o_row_check   = (state == S_CLEAR);
    assign o_row_idx     = scan_row;
    assign o_active_code = piece_code;

    // Parked off the field while idle
    assign o_active_cells = (state == S_IDLE) ? '1 : active_cells;
    assign o_ghost_cells  = (state == S_IDLE) ? '1 : ghost_cells;

endmodule

//--- pixel_render.sv
module pixel_render (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  tetris_pkg::coord_t i_x,
    input  tetris_pkg::coord_t i_y,
    input  tetris_pkg::board_t i_board,
    input  tetris_pkg::cells_t i_active_cells,
    input  tetris_pkg::cells_t i_ghost_cells,
    input  tetris_pkg::cell_t  i_active_code,
    output logic [7:0]         o_vga_r,
    output logic [7:0]         o_vga_g,
    output logic [7:0]         o_vga_b
);

    tetris_pkg::coord_t dx;
    tetris_pkg::coord_t dy;
    tetris_pkg::col_t   pix_col;
    tetris_pkg::row_t   pix_row;
    logic               in_field;
    logic               on_grid;
    logic               on_active;
    logic               on_ghost;
    tetris_pkg::rgb_t   color;

    assign dx = i_x - tetris_pkg::coord_t'(tetris_pkg::FIELD_X0);
    assign dy = i_y - tetris_pkg::coord_t'(tetris_pkg::FIELD_Y0);

    assign in_field = (i_x >= tetris_pkg::FIELD_X0)
                   && (i_x <= tetris_pkg::FIELD_X0 + tetris_pkg::COLS * tetris_pkg::CELL_PIX)
                   && (i_y >= tetris_pkg::FIELD_Y0)
                   && (i_y <= tetris_pkg::FIELD_Y0 + tetris_pkg::ROWS * tetris_pkg::CELL_PIX);

    assign on_grid = (dx % tetris_pkg::CELL_PIX == 0) || (dy % tetris_pkg::CELL_PIX == 0);
    assign pix_col = tetris_pkg::col_t'(dx / tetris_pkg::CELL_PIX);
    assign pix_row = tetris_pkg::row_t'(dy / tetris_pkg::CELL_PIX);

    always_comb begin
        on_active = 1'b0;
        on_ghost  = 1'b0;
        for (int k = 0; k < 4; k++) begin
            if (i_active_cells[k].col == pix_col && i_active_cells[k].row == pix_row) begin
                on_active = 1'b1;
            end
            if (i_ghost_cells[k].col == pix_col && i_ghost_cells[k].row == pix_row) begin
                on_ghost = 1'b1;
            end
        end
    end

    always_comb begin
        if (!in_field) begin
            color = tetris_pkg::BACK_COLOR;
        end else if (on_grid) begin
            color = tetris_pkg::GRID_COLOR;
        end else if (on_active) begin
            color = tetris_pkg::CELL_COLORS[i_active_code];
        end else if (on_ghost) begin
            color = tetris_pkg::GHOST_COLOR;
        end else begin
            color = tetris_pkg::CELL_COLORS[i_board[pix_col][pix_row]];
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_vga_r <= '0;
            o_vga_g <= '0;
            o_vga_b <= '0;
        end else begin
            o_vga_r <= color.r;
            o_vga_g <= color.g;
            o_vga_b <= color.b;
        end
    end

endmodule

//--- tetris_game.sv
module tetris_game (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_start,
    input  tetris_pkg::coord_t i_x,
    input  tetris_pkg::coord_t i_y,
    input  logic [7:0]         i_key,
    output logic [7:0]         o_vga_r,
    output logic [7:0]         o_vga_g,
    output logic [7:0]         o_vga_b
);

    tetris_pkg::board_t board;
    logic               board_clear;
    logic               lock_we;
    tetris_pkg::cells_t lock_cells;
    tetris_pkg::cell_t  lock_code;
    logic               row_check;
    tetris_pkg::row_t   row_idx;
    tetris_pkg::cells_t active_cells;
    tetris_pkg::cells_t ghost_cells;
    tetris_pkg::cell_t  active_code;

    game_fsm u_fsm (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_start        (i_start),
        .i_key          (i_key),
        .i_board        (board),
        .o_board_clear  (board_clear),
        .o_lock_we      (lock_we),
        .o_lock_cells   (lock_cells),
        .o_lock_code    (lock_code),
        .o_row_check    (row_check),
        .o_row_idx      (row_idx),
        .o_active_cells (active_cells),
        .o_ghost_cells  (ghost_cells),
        .o_active_code  (active_code)
    );

    board_store u_board (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_clear      (board_clear),
        .i_lock_we    (lock_we),
        .i_lock_cells (lock_cells),
        .i_lock_code  (lock_code),
        .i_row_check  (row_check),
        .i_row_idx    (row_idx),
        .o_board      (board)
    );

    pixel_render u_render (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_x            (i_x),
        .i_y            (i_y),
        .i_board        (board),
        .i_active_cells (active_cells),
        .i_ghost_cells  (ghost_cells),
        .i_active_code  (active_code),
        .o_vga_r        (o_vga_r),
        .o_vga_g        (o_vga_g),
        .o_vga_b        (o_vga_b)
    );

endmodule

//--- tb_tetris_game.sv
module tb_tetris_game;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int KEY_WAIT = tetris_pkg::SETTLE_CYCLES + 8;
    // Lock, 20-row clear scan, then a full settle of the next piece
    localparam int LOCK_WAIT = 25 + tetris_pkg::SETTLE_CYCLES + 8;
    localparam int MAX_PIECES = 60;
    localparam int MAX_KEYS = 8;
    localparam int SCAN_CYCLES = 2 * tetris_pkg::COLS * tetris_pkg::ROWS;
    localparam int LIMIT = (MAX_PIECES * (MAX_KEYS * KEY_WAIT + LOCK_WAIT + 2 * SCAN_CYCLES)
                          + tetris_pkg::GRAVITY_CYCLES + 2000) * 2;

    logic               i_clk;
    logic               i_rst_n;
    logic               i_start;
    tetris_pkg::coord_t i_x;
    tetris_pkg::coord_t i_y;
    logic [7:0]         i_key;
    logic [7:0]         o_vga_r;
    logic [7:0]         o_vga_g;
    logic [7:0]         o_vga_b;

    // Reference game model
    int board_m [tetris_pkg::COLS][tetris_pkg::ROWS];
    int col_m;
    int row_m;
    int ghost_m;
    int shape_m;
    int rot_m;
    bit idle_m;
    bit cleared_seen;
    bit over_seen;
    int seed = 20;
    int cycles = 0;
    logic [7:0] move_keys [4];

    tetris_game tetris_game_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_start (i_start),
        .i_x     (i_x),
        .i_y     (i_y),
        .i_key   (i_key),
        .o_vga_r (o_vga_r),
        .o_vga_g (o_vga_g),
        .o_vga_b (o_vga_b)
    );

    always #20 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if (cycles > LIMIT) begin
            $display("Timeout: the run went past %0d clock cycles", LIMIT);
            $display("SIMULATION FAILED");
            $fatal(1, "timeout");
        end
    end

    function automatic int cell_col(int c, int s, int rt, int k);
        if (k == 0) begin
            return c;
        end
        return c + int'(tetris_pkg::SHAPE_OFFSETS[s][rt][k-1].dc);
    endfunction

    function automatic int cell_row(int r, int s, int rt, int k);
        if (k == 0) begin
            return r;
        end
        return r + int'(tetris_pkg::SHAPE_OFFSETS[s][rt][k-1].dr);
    endfunction

    function automatic bit piece_fits(int c, int r, int s, int rt);
        int cc;
        int rr;
        for (int k = 0; k < 4; k++) begin
            cc = cell_col(c, s, rt, k);
            rr = cell_row(r, s, rt, k);
            if (cc < 0 || cc >= tetris_pkg::COLS || rr < 0 || rr >= tetris_pkg::ROWS) begin
                return 1'b0;
            end
            if (board_m[cc][rr] != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    function automatic bit piece_covers(int c, int r, int s, int rt, int qc, int qr);
        for (int k = 0; k < 4; k++) begin
            if (cell_col(c, s, rt, k) == qc && cell_row(r, s, rt, k) == qr) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    function automatic int landing_row(int c, int r, int s, int rt);
        int g;
        g = r;
        while (g < tetris_pkg::ROWS && piece_fits(c, g + 1, s, rt)) begin
            g++;
        end
        return g;
    endfunction

    // Expected colour at the centre of a cell
    function automatic tetris_pkg::rgb_t expected_color(int r, int c);
        if (!idle_m && piece_covers(col_m, row_m, shape_m, rot_m, c, r)) begin
            return tetris_pkg::CELL_COLORS[shape_m + 1];
        end
        if (!idle_m && piece_covers(col_m, ghost_m, shape_m, rot_m, c, r)) begin
            return tetris_pkg::GHOST_COLOR;
        end
        return tetris_pkg::CELL_COLORS[board_m[c][r]];
    endfunction

    task automatic settle_model();
        ghost_m = landing_row(col_m, row_m, shape_m, rot_m);
        if (ghost_m == 0) begin
            idle_m = 1'b1;
            over_seen = 1'b1;
        end
    endtask

    task automatic spawn_model(int s);
        shape_m = s;
        rot_m = 0;
        col_m = int'(tetris_pkg::SPAWN_COL);
        row_m = int'(tetris_pkg::SPAWN_ROW);
        settle_model();
    endtask

    task automatic lock_model();
        bit full;
        for (int k = 0; k < 4; k++) begin
            board_m[cell_col(col_m, shape_m, rot_m, k)][cell_row(ghost_m, shape_m, rot_m, k)]
                = shape_m + 1;
        end
        for (int r = 0; r < tetris_pkg::ROWS; r++) begin
            full = 1'b1;
            for (int c = 0; c < tetris_pkg::COLS; c++) begin
                if (board_m[c][r] == 0) begin
                    full = 1'b0;
                end
            end
            if (full) begin
                cleared_seen = 1'b1;
                for (int c = 0; c < tetris_pkg::COLS; c++) begin
                    for (int rr = r; rr > 0; rr--) begin
                        board_m[c][rr] = board_m[c][rr-1];
                    end
                    board_m[c][0] = 0;
                end
            end
        end
        spawn_model((shape_m + 1) % 7);
    endtask

    task automatic apply_key_model(logic [7:0] code);
        int cc;
        int crt;
        cc = col_m;
        crt = rot_m;
        if (code == tetris_pkg::KEY_DOWN) begin
            lock_model();
        end else begin
            if (code == tetris_pkg::KEY_LEFT) cc = col_m - 1;
            if (code == tetris_pkg::KEY_RIGHT) cc = col_m + 1;
            if (code == tetris_pkg::KEY_UP) crt = (rot_m + 1) % 4;
            if (piece_fits(cc, row_m, shape_m, crt)) begin
                col_m = cc;
                rot_m = crt;
                settle_model();
            end
        end
    endtask

    task automatic press_key(logic [7:0] code);
        // A key pressed while idle would stay pending into the next game
        if (!idle_m) begin
            @(posedge i_clk);
            i_key <= code;
            @(posedge i_clk);
            i_key <= 8'h00;
            apply_key_model(code);
            repeat ((code == tetris_pkg::KEY_DOWN) ? LOCK_WAIT : KEY_WAIT) @(posedge i_clk);
        end
    endtask

    task automatic start_game();
        @(posedge i_clk);
        i_start <= 1'b1;
        @(posedge i_clk);
        i_start <= 1'b0;
        foreach (board_m[c, r]) begin
            board_m[c][r] = 0;
        end
        idle_m = 1'b0;
        spawn_model(0);
        repeat (KEY_WAIT) @(posedge i_clk);
    endtask

    task automatic sample_rgb(tetris_pkg::coord_t x, tetris_pkg::coord_t y,
                              output tetris_pkg::rgb_t got);
        @(posedge i_clk);
        i_x <= x;
        i_y <= y;
        @(posedge i_clk);
        @(negedge i_clk);
        got.r = o_vga_r;
        got.g = o_vga_g;
        got.b = o_vga_b;
    endtask

    task automatic check_point(tetris_pkg::coord_t x, tetris_pkg::coord_t y,
                               tetris_pkg::rgb_t exp);
        tetris_pkg::rgb_t got;
        sample_rgb(x, y, got);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: pixel (%0d,%0d) got %h expected %h", $time, x, y, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "pixel mismatch");
        end
    endtask

    task automatic check_pixel(tetris_pkg::row_t row, tetris_pkg::col_t col,
                               tetris_pkg::rgb_t exp);
        tetris_pkg::rgb_t got;
        tetris_pkg::coord_t x;
        tetris_pkg::coord_t y;
        x = tetris_pkg::coord_t'(tetris_pkg::FIELD_X0 + int'(col) * tetris_pkg::CELL_PIX
                                 + tetris_pkg::CELL_PIX / 2);
        y = tetris_pkg::coord_t'(tetris_pkg::FIELD_Y0 + int'(row) * tetris_pkg::CELL_PIX
                                 + tetris_pkg::CELL_PIX / 2);
        sample_rgb(x, y, got);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: cell row %0d col %0d got %h expected %h",
                     $time, row, col, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "cell mismatch");
        end
    endtask

    task automatic scan_board();
        for (int r = 0; r < tetris_pkg::ROWS; r++) begin
            for (int c = 0; c < tetris_pkg::COLS; c++) begin
                check_pixel(tetris_pkg::row_t'(r), tetris_pkg::col_t'(c), expected_color(r, c));
            end
        end
    endtask

    // Landing depth of a rotate-then-shift plan, summed over the four cells
    function automatic int plan_depth(int rots, int target);
        int c;
        int rt;
        int g;
        int sum;
        c = col_m;
        rt = rot_m;
        sum = 0;
        for (int i = 0; i < rots; i++) begin
            if (piece_fits(c, row_m, shape_m, (rt + 1) % 4)) rt = (rt + 1) % 4;
        end
        while (c != target && piece_fits(c + ((target > c) ? 1 : -1), row_m, shape_m, rt)) begin
            c = c + ((target > c) ? 1 : -1);
        end
        g = landing_row(c, row_m, shape_m, rt);
        for (int k = 0; k < 4; k++) begin
            sum += cell_row(g, shape_m, rt, k);
        end
        return sum;
    endfunction

    task automatic place_low();
        int best;
        int score;
        int best_rot;
        int best_col;
        int dir;
        best = -1;
        best_rot = 0;
        best_col = col_m;
        for (int r = 0; r < 4; r++) begin
            for (int t = 0; t < tetris_pkg::COLS; t++) begin
                score = plan_depth(r, t) * 64 + ($random(seed) & 63);
                if (score > best) begin
                    best = score;
                    best_rot = r;
                    best_col = t;
                end
            end
        end
        repeat (best_rot) press_key(tetris_pkg::KEY_UP);
        while (!idle_m && col_m != best_col) begin
            dir = (best_col > col_m) ? 1 : -1;
            if (!piece_fits(col_m + dir, row_m, shape_m, rot_m)) break;
            press_key((dir > 0) ? tetris_pkg::KEY_RIGHT : tetris_pkg::KEY_LEFT);
        end
        press_key(tetris_pkg::KEY_DOWN);
    endtask

    task automatic place_random();
        int n;
        n = $random(seed) & 3;
        repeat (n) press_key(move_keys[$random(seed) & 3]);
        press_key(tetris_pkg::KEY_DOWN);
    endtask

    initial begin
        int pieces;
        i_clk = 1'b0;
        i_rst_n = 1'b0;
        i_start = 1'b0;
        i_key = 8'h00;
        i_x = '0;
        i_y = '0;
        move_keys[0] = tetris_pkg::KEY_LEFT;
        move_keys[1] = tetris_pkg::KEY_RIGHT;
        move_keys[2] = tetris_pkg::KEY_UP;
        move_keys[3] = tetris_pkg::KEY_LEFT;
        foreach (board_m[c, r]) begin
            board_m[c][r] = 0;
        end
        idle_m = 1'b1;
        cleared_seen = 1'b0;
        over_seen = 1'b0;
        repeat (3) @(posedge i_clk);
        i_rst_n <= 1'b1;
        @(posedge i_clk);

        // Empty field after reset
        scan_board();
        check_point(10'd220, 10'd50, tetris_pkg::GRID_COLOR);
        check_point(10'd440, 10'd50, tetris_pkg::BACK_COLOR);

        start_game();
        scan_board();

        // One gravity step with no key
        repeat (tetris_pkg::GRAVITY_CYCLES + tetris_pkg::SETTLE_CYCLES + 20) @(posedge i_clk);
        row_m = row_m + 1;
        scan_board();

        // Moves, a refused move at the left wall, rotations
        press_key(tetris_pkg::KEY_LEFT);
        scan_board();
        press_key(tetris_pkg::KEY_LEFT);
        scan_board();
        press_key(tetris_pkg::KEY_LEFT);
        scan_board();
        press_key(tetris_pkg::KEY_LEFT);
        scan_board();
        press_key(tetris_pkg::KEY_RIGHT);
        scan_board();
        press_key(tetris_pkg::KEY_UP);
        scan_board();
        press_key(tetris_pkg::KEY_UP);
        scan_board();
        press_key(tetris_pkg::KEY_RIGHT);
        scan_board();

        pieces = 0;
        while (!(cleared_seen && over_seen)) begin
            if (pieces >= MAX_PIECES) begin
                $display("Random play ended without both a row clear and a game over");
                $display("SIMULATION FAILED");
                $fatal(1, "piece limit");
            end
            if (!cleared_seen) begin
                place_low();
            end else begin
                place_random();
            end
            pieces++;
            scan_board();
            if (idle_m) begin
                start_game();
                scan_board();
            end
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- vlog.f
tetris_pkg.sv
piece_cells.sv
piece_fit.sv
board_store.sv
game_fsm.sv
pixel_render.sv
tetris_game.sv
tb_tetris_game.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench, exit status carries pass or fail
verilator --binary --timing -sv -f vlog.f --top-module tb_tetris_game -Mdir obj_dir \
    && ./obj_dir/Vtb_tetris_game \
    || exit 1
